//--- src/sldu_pkg.sv
//////////////////////////////////////////////////////////////////////
// Slide unit package
// Sizes, opcodes and packed structs shared by the vector slide unit
//////////////////////////////////////////////////////////////////////

package sldu_pkg;

  // Lane organisation
  localparam int unsigned NrLanes   = 4;
  localparam int unsigned ElenBytes = 8;
  localparam int unsigned WordBytes = NrLanes * ElenBytes;

  // Vector register geometry
  localparam int unsigned VlenBytes   = 256;
  localparam int unsigned WordsPerReg = VlenBytes / WordBytes;

  // Instruction ids and queue depths
  localparam int unsigned NrVInsn          = 8;
  localparam int unsigned InsnQueueDepth   = 2;
  localparam int unsigned ResultQueueDepth = 2;

  // Byte pointer inside a word, wide enough to hold WordBytes itself
  localparam int unsigned PntWidth = $clog2(WordBytes) + 1;
  // Word index inside one register
  localparam int unsigned WordIdxWidth = $clog2(WordsPerReg);

  // Basic types
  typedef logic [8*ElenBytes-1:0]           elen_t;
  typedef logic [ElenBytes-1:0]             strb_t;
  typedef logic [$clog2(NrVInsn)-1:0]       vid_t;
  typedef logic [4:0]                       vreg_t;
  typedef logic [7:0]                       vaddr_t;
  typedef logic [$clog2(VlenBytes):0]       blen_t;

  // Per-lane bundles, lane 0 in the low bits
  typedef elen_t [NrLanes-1:0] lane_data_t;
  typedef strb_t [NrLanes-1:0] lane_strb_t;
  typedef logic  [NrLanes-1:0] lane_bits_t;
  typedef logic  [NrVInsn-1:0] done_vec_t;

  // Element width code, also the shift from elements to bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef enum logic {
    SLIDE_UP   = 1'b0,
    SLIDE_DOWN = 1'b1
  } slide_op_e;

  // Instruction as sent by the sequencer, counts in elements
  typedef struct packed {
    vid_t      id;
    slide_op_e op;
    vew_e      vsew;
    blen_t     vl;
    blen_t     offset;
    vreg_t     vd;
  } slide_req_t;

  // Queued instruction, counts already converted to bytes
  typedef struct packed {
    vid_t      id;
    slide_op_e op;
    vreg_t     vd;
    blen_t     byte_off;
    blen_t     byte_len;
  } slide_insn_t;

  // One destination word on its way to the register file
  typedef struct packed {
    vid_t       id;
    vaddr_t     addr;
    lane_data_t wdata;
    lane_strb_t be;
    logic       last;
  } result_word_t;

endpackage

//--- src/sldu_insn_queue.sv
//////////////////////////////////////////////////////////////////////
// Slide instruction queue
// Holds up to two instructions from accept until their last result
// word has been written back
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sldu_insn_queue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Sequencer side
  input  sldu_pkg::slide_req_t  req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  // Engine side
  output sldu_pkg::slide_insn_t issue_insn_o,
  output logic                  issue_valid_o,
  input  logic                  issue_done_i,
  // Result queue side
  input  logic                  commit_done_i
);

  typedef logic [$clog2(sldu_pkg::InsnQueueDepth)-1:0] pnt_t;
  typedef logic [$clog2(sldu_pkg::InsnQueueDepth):0]   cnt_t;

  // Instruction storage
  sldu_pkg::slide_insn_t [sldu_pkg::InsnQueueDepth-1:0] queue_q;

  // Issue and commit phase bookkeeping
  pnt_t issue_pnt_d, issue_pnt_q;
  pnt_t commit_pnt_d, commit_pnt_q;
  cnt_t issue_cnt_d, issue_cnt_q;
  cnt_t commit_cnt_d, commit_cnt_q;

  // Accept slot sits right behind the oldest uncommitted entry
  cnt_t                  accept_sum;
  pnt_t                  accept_pnt;
  logic                  accept;
  sldu_pkg::slide_insn_t new_insn;

  // Space is counted up to commit, not issue
  assign req_ready_o = (commit_cnt_q != cnt_t'(sldu_pkg::InsnQueueDepth));
  assign accept      = req_valid_i && req_ready_o;

  assign issue_insn_o  = queue_q[issue_pnt_q];
  assign issue_valid_o = (issue_cnt_q != '0);

  always_comb begin
    accept_sum = cnt_t'(commit_pnt_q) + commit_cnt_q;
    if (accept_sum >= cnt_t'(sldu_pkg::InsnQueueDepth)) begin
      accept_pnt = pnt_t'(accept_sum - cnt_t'(sldu_pkg::InsnQueueDepth));
    end else begin
      accept_pnt = pnt_t'(accept_sum);
    end
  end

  // Element counts become byte counts here
  always_comb begin
    new_insn.id       = req_i.id;
    new_insn.op       = req_i.op;
    new_insn.vd       = req_i.vd;
    new_insn.byte_off = req_i.offset << req_i.vsew;
    new_insn.byte_len = req_i.vl << req_i.vsew;
  end

  always_comb begin
    issue_pnt_d  = issue_pnt_q;
    commit_pnt_d = commit_pnt_q;

    // Engine finished the head instruction
    if (issue_done_i) begin
      if (issue_pnt_q == pnt_t'(sldu_pkg::InsnQueueDepth - 1)) begin
        issue_pnt_d = '0;
      end else begin
        issue_pnt_d = issue_pnt_q + 1'b1;
      end
    end

    // Last word of the oldest instruction left the result queue
    if (commit_done_i) begin
      if (commit_pnt_q == pnt_t'(sldu_pkg::InsnQueueDepth - 1)) begin
        commit_pnt_d = '0;
      end else begin
        commit_pnt_d = commit_pnt_q + 1'b1;
      end
    end

    issue_cnt_d  = issue_cnt_q + cnt_t'(accept) - cnt_t'(issue_done_i);
    commit_cnt_d = commit_cnt_q + cnt_t'(accept) - cnt_t'(commit_done_i);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
    end else begin
      issue_pnt_q  <= issue_pnt_d;
      commit_pnt_q <= commit_pnt_d;
      issue_cnt_q  <= issue_cnt_d;
      commit_cnt_q <= commit_cnt_d;
    end
  end

  // Entry payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      queue_q[accept_pnt] <= new_insn;
    end
  end

endmodule

//--- src/sldu_slide_engine.sv
//////////////////////////////////////////////////////////////////////
// Slide engine
// Moves source bytes by the slide offset and packs them into
// destination words with byte strobes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sldu_slide_engine (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Instruction from the queue
  input  sldu_pkg::slide_insn_t  issue_insn_i,
  input  logic                   issue_valid_i,
  output logic                   issue_done_o,
  // Source operand stream from the lanes
  input  sldu_pkg::lane_data_t   operand_i,
  input  sldu_pkg::lane_bits_t   operand_valid_i,
  output sldu_pkg::lane_bits_t   operand_ready_o,
  // Result queue
  input  logic                   rq_full_i,
  output logic                   push_valid_o,
  output sldu_pkg::result_word_t push_word_o
);

  localparam int unsigned WordBits = 8 * sldu_pkg::WordBytes;

  typedef logic [sldu_pkg::PntWidth-1:0]     pnt_t;
  typedef logic [sldu_pkg::WordIdxWidth-1:0] widx_t;

  typedef enum logic {
    SLIDE_IDLE,
    SLIDE_RUN
  } state_e;

  state_e state_d, state_q;

  // Byte pointers inside the current source and destination words
  pnt_t           in_pnt_d, in_pnt_q;
  pnt_t           out_pnt_d, out_pnt_q;
  // Destination word inside the register
  widx_t          word_idx_d, word_idx_q;
  // Bytes still to move for this instruction
  sldu_pkg::blen_t remain_d, remain_q;

  // Destination word under construction
  logic [WordBits-1:0]            stage_data_d, stage_data_q;
  logic [sldu_pkg::WordBytes-1:0] stage_be_d, stage_be_q;

  // Step sizing
  pnt_t in_left;
  pnt_t out_left;
  pnt_t step;
  pnt_t copy;
  pnt_t in_nxt;
  pnt_t out_nxt;
  logic last_step;

  logic [WordBits-1:0] operand_flat;

  // Byte b of the word is byte b mod 8 of lane b/8
  assign operand_flat = operand_i;

  always_comb begin
    int unsigned src;
    int unsigned dst;

    state_d      = state_q;
    in_pnt_d     = in_pnt_q;
    out_pnt_d    = out_pnt_q;
    word_idx_d   = word_idx_q;
    remain_d     = remain_q;
    stage_data_d = stage_data_q;
    stage_be_d   = stage_be_q;

    issue_done_o    = 1'b0;
    push_valid_o    = 1'b0;
    operand_ready_o = '0;

    // Limited by whichever word runs out first
    in_left   = pnt_t'(sldu_pkg::WordBytes) - in_pnt_q;
    out_left  = pnt_t'(sldu_pkg::WordBytes) - out_pnt_q;
    step      = (in_left < out_left) ? in_left : out_left;
    last_step = (remain_q <= sldu_pkg::blen_t'(step));
    copy      = last_step ? pnt_t'(remain_q) : step;
    in_nxt    = in_pnt_q + step;
    out_nxt   = out_pnt_q + step;

    // Word fields that do not depend on the step
    push_word_o.id    = issue_insn_i.id;
    push_word_o.addr  = sldu_pkg::vaddr_t'(issue_insn_i.vd) *
                        sldu_pkg::vaddr_t'(sldu_pkg::WordsPerReg) +
                        sldu_pkg::vaddr_t'(word_idx_q);
    push_word_o.wdata = stage_data_q;
    push_word_o.be    = stage_be_q;
    push_word_o.last  = last_step;

    unique case (state_q)
      SLIDE_IDLE: begin
        if (issue_valid_i) begin
          state_d      = SLIDE_RUN;
          stage_data_d = '0;
          stage_be_d   = '0;
          if (issue_insn_i.op == sldu_pkg::SLIDE_UP) begin
            // Source from byte 0, destination from the offset
            in_pnt_d   = '0;
            out_pnt_d  = pnt_t'(issue_insn_i.byte_off % sldu_pkg::WordBytes);
            word_idx_d = widx_t'(issue_insn_i.byte_off / sldu_pkg::WordBytes);
            remain_d   = issue_insn_i.byte_len - issue_insn_i.byte_off;
          end else begin
            // Stream already starts at the word holding the offset
            in_pnt_d   = pnt_t'(issue_insn_i.byte_off % sldu_pkg::WordBytes);
            out_pnt_d  = '0;
            word_idx_d = '0;
            remain_d   = issue_insn_i.byte_len;
          end
        end
      end

      SLIDE_RUN: begin
        // Need a full word from every lane and room downstream
        if (&operand_valid_i && !rq_full_i) begin
          for (int b = 0; b < sldu_pkg::WordBytes; b++) begin
            src = int'(in_pnt_q) + b;
            dst = int'(out_pnt_q) + b;
            if (b < int'(copy) && src < sldu_pkg::WordBytes &&
                dst < sldu_pkg::WordBytes) begin
              stage_data_d[8*dst +: 8] = operand_flat[8*src +: 8];
              stage_be_d[dst]          = 1'b1;
            end
          end

          push_word_o.wdata = stage_data_d;
          push_word_o.be    = stage_be_d;

          in_pnt_d  = in_nxt;
          out_pnt_d = out_nxt;
          remain_d  = remain_q - sldu_pkg::blen_t'(step);

          // Source word used up
          if (in_nxt == pnt_t'(sldu_pkg::WordBytes) || last_step) begin
            in_pnt_d        = '0;
            operand_ready_o = '1;
          end

          // Destination word complete
          if (out_nxt == pnt_t'(sldu_pkg::WordBytes) || last_step) begin
            out_pnt_d    = '0;
            push_valid_o = 1'b1;
            word_idx_d   = word_idx_q + 1'b1;
            stage_data_d = '0;
            stage_be_d   = '0;
          end

          if (last_step) begin
            state_d      = SLIDE_IDLE;
            remain_d     = '0;
            issue_done_o = 1'b1;
          end
        end
      end

      default: begin
        state_d = SLIDE_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= SLIDE_IDLE;
      in_pnt_q   <= '0;
      out_pnt_q  <= '0;
      word_idx_q <= '0;
      remain_q   <= '0;
    end else begin
      state_q    <= state_d;
      in_pnt_q   <= in_pnt_d;
      out_pnt_q  <= out_pnt_d;
      word_idx_q <= word_idx_d;
      remain_q   <= remain_d;
    end
  end

  // Staging word, cleared on every instruction start
  always_ff @(posedge clk_i) begin
    stage_data_q <= stage_data_d;
    stage_be_q   <= stage_be_d;
  end

endmodule

//--- src/sldu_result_queue.sv
//////////////////////////////////////////////////////////////////////
// Slide result queue
// Two-deep word queue toward the register file with per-lane grants
// and done reporting per instruction id
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sldu_result_queue (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Engine side
  input  logic                   push_valid_i,
  input  sldu_pkg::result_word_t push_word_i,
  output logic                   full_o,
  // Register file write, one request per lane
  output sldu_pkg::lane_bits_t   result_req_o,
  output sldu_pkg::vaddr_t       result_addr_o,
  output sldu_pkg::vid_t         result_id_o,
  output sldu_pkg::lane_data_t   result_wdata_o,
  output sldu_pkg::lane_strb_t   result_be_o,
  input  sldu_pkg::lane_bits_t   result_gnt_i,
  // Completion
  output logic                   commit_done_o,
  output sldu_pkg::done_vec_t    done_o
);

  typedef logic [$clog2(sldu_pkg::ResultQueueDepth)-1:0] pnt_t;
  typedef logic [$clog2(sldu_pkg::ResultQueueDepth):0]   cnt_t;

  sldu_pkg::result_word_t [sldu_pkg::ResultQueueDepth-1:0] words_q;

  // Lanes that have not yet granted each entry
  sldu_pkg::lane_bits_t [sldu_pkg::ResultQueueDepth-1:0] valid_d, valid_q;

  pnt_t                wr_pnt_d, wr_pnt_q;
  pnt_t                rd_pnt_d, rd_pnt_q;
  cnt_t                cnt_d, cnt_q;
  logic                pop;
  sldu_pkg::done_vec_t done_d;

  assign full_o = (cnt_q == cnt_t'(sldu_pkg::ResultQueueDepth));

  // Head word drives every lane
  assign result_req_o   = valid_q[rd_pnt_q];
  assign result_addr_o  = words_q[rd_pnt_q].addr;
  assign result_id_o    = words_q[rd_pnt_q].id;
  assign result_wdata_o = words_q[rd_pnt_q].wdata;
  assign result_be_o    = words_q[rd_pnt_q].be;

  always_comb begin
    valid_d  = valid_q;
    wr_pnt_d = wr_pnt_q;
    rd_pnt_d = rd_pnt_q;
    cnt_d    = cnt_q;
    done_d   = '0;

    // A granted lane drops its request
    valid_d[rd_pnt_q] = valid_q[rd_pnt_q] & ~result_gnt_i;

    // Head leaves once every lane took it
    pop           = (cnt_q != '0) && (valid_d[rd_pnt_q] == '0);
    commit_done_o = pop && words_q[rd_pnt_q].last;

    if (pop) begin
      if (rd_pnt_q == pnt_t'(sldu_pkg::ResultQueueDepth - 1)) begin
        rd_pnt_d = '0;
      end else begin
        rd_pnt_d = rd_pnt_q + 1'b1;
      end
      if (words_q[rd_pnt_q].last) begin
        done_d[words_q[rd_pnt_q].id] = 1'b1;
      end
    end

    if (push_valid_i) begin
      valid_d[wr_pnt_q] = '1;
      if (wr_pnt_q == pnt_t'(sldu_pkg::ResultQueueDepth - 1)) begin
        wr_pnt_d = '0;
      end else begin
        wr_pnt_d = wr_pnt_q + 1'b1;
      end
    end

    cnt_d = cnt_q + cnt_t'(push_valid_i) - cnt_t'(pop);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
      done_o   <= '0;
    end else begin
      valid_q  <= valid_d;
      wr_pnt_q <= wr_pnt_d;
      rd_pnt_q <= rd_pnt_d;
      cnt_q    <= cnt_d;
      done_o   <= done_d;
    end
  end

  // Word payload
  always_ff @(posedge clk_i) begin
    if (push_valid_i) begin
      words_q[wr_pnt_q] <= push_word_i;
    end
  end

endmodule

//--- src/sldu_top.sv
//////////////////////////////////////////////////////////////////////
// Vector slide unit
// Instruction queue, slide engine and result queue for four lanes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sldu_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Sequencer
  input  sldu_pkg::slide_req_t req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  // Operand stream
  input  sldu_pkg::lane_data_t operand_i,
  input  sldu_pkg::lane_bits_t operand_valid_i,
  output sldu_pkg::lane_bits_t operand_ready_o,
  // Result write
  output sldu_pkg::lane_bits_t result_req_o,
  output sldu_pkg::vaddr_t     result_addr_o,
  output sldu_pkg::vid_t       result_id_o,
  output sldu_pkg::lane_data_t result_wdata_o,
  output sldu_pkg::lane_strb_t result_be_o,
  input  sldu_pkg::lane_bits_t result_gnt_i,
  // Completion
  output sldu_pkg::done_vec_t  done_o
);

  // Queue to engine
  sldu_pkg::slide_insn_t  issue_insn;
  logic                   issue_valid;
  logic                   issue_done;

  // Engine to result queue
  logic                   rq_full;
  logic                   push_valid;
  sldu_pkg::result_word_t push_word;

  // Result queue back to the instruction queue
  logic                   commit_done;

  sldu_insn_queue u_insn_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .issue_insn_o  (issue_insn),
    .issue_valid_o (issue_valid),
    .issue_done_i  (issue_done),
    .commit_done_i (commit_done)
  );

  sldu_slide_engine u_engine (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .issue_insn_i    (issue_insn),
    .issue_valid_i   (issue_valid),
    .issue_done_o    (issue_done),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .rq_full_i       (rq_full),
    .push_valid_o    (push_valid),
    .push_word_o     (push_word)
  );

  sldu_result_queue u_result_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_valid_i   (push_valid),
    .push_word_i    (push_word),
    .full_o         (rq_full),
    .result_req_o   (result_req_o),
    .result_addr_o  (result_addr_o),
    .result_id_o    (result_id_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i),
    .commit_done_o  (commit_done),
    .done_o         (done_o)
  );

endmodule

//--- testbench/tb_sldu_model.svh
//////////////////////////////////////////////////////////////////////
// Slide unit reference model
// LFSR random source and the expected operand and result words
//////////////////////////////////////////////////////////////////////

`ifndef TB_SLDU_MODEL_SVH
`define TB_SLDU_MODEL_SVH

// x^32 + x^22 + x^2 + x + 1, right-shifting form
localparam logic [31:0] LfsrTaps = 32'h8020_0003;

function automatic logic [31:0] galois_step(input logic [31:0] s);
  if (s[0]) begin
    return (s >> 1) ^ LfsrTaps;
  end else begin
    return s >> 1;
  end
endfunction

// Stimulus stream, one LFSR step per bit
function automatic logic [31:0] stim_bits(input int unsigned n);
  logic [31:0] v;
  v = '0;
  for (int unsigned i = 0; i < n; i++) begin
    v = {v[30:0], stim_lfsr[0]};
    stim_lfsr = galois_step(stim_lfsr);
  end
  return v;
endfunction

// Separate stream for the lane responders
function automatic logic [31:0] lane_bits(input int unsigned n);
  logic [31:0] v;
  v = '0;
  for (int unsigned i = 0; i < n; i++) begin
    v = {v[30:0], lane_lfsr[0]};
    lane_lfsr = galois_step(lane_lfsr);
  end
  return v;
endfunction

// Fresh source register per slide, then queue the words the lanes
// stream in and the words the register file must see
function automatic void build_expect(input sldu_pkg::slide_req_t req);
  logic [7:0]             src [sldu_pkg::VlenBytes];
  sldu_pkg::lane_data_t   od;
  sldu_pkg::result_word_t w;
  int unsigned            boff;
  int unsigned            blen;
  int unsigned            first_sw;
  int unsigned            last_sw;
  int unsigned            last_w;
  int unsigned            db;
  int unsigned            sb;
  logic                   up;
  logic                   hit;

  boff = int'(req.offset) << int'(req.vsew);
  blen = int'(req.vl) << int'(req.vsew);
  up   = (req.op == sldu_pkg::SLIDE_UP);
  for (int unsigned i = 0; i < sldu_pkg::VlenBytes; i++) begin
    src[i] = 8'(stim_bits(8));
  end

  // Slide-up reads from word 0, slide-down from the word holding the offset
  if (up) begin
    first_sw = 0;
    last_sw  = (blen - boff - 1) / sldu_pkg::WordBytes;
  end else begin
    first_sw = boff / sldu_pkg::WordBytes;
    last_sw  = (boff + blen - 1) / sldu_pkg::WordBytes;
  end
  for (int unsigned k = first_sw; k <= last_sw; k++) begin
    for (int unsigned b = 0; b < sldu_pkg::WordBytes; b++) begin
      od[b / sldu_pkg::ElenBytes][8 * (b % sldu_pkg::ElenBytes) +: 8] =
        src[k * sldu_pkg::WordBytes + b];
    end
    op_words.push_back(od);
  end

  // Words below the offset are never written on slide-up
  last_w = (blen - 1) / sldu_pkg::WordBytes;
  for (int unsigned wi = (up ? boff / sldu_pkg::WordBytes : 0); wi <= last_w; wi++) begin
    w      = '0;
    w.id   = req.id;
    w.addr = sldu_pkg::vaddr_t'(req.vd * sldu_pkg::WordsPerReg + wi);
    w.last = (wi == last_w);
    for (int unsigned b = 0; b < sldu_pkg::WordBytes; b++) begin
      db  = wi * sldu_pkg::WordBytes + b;
      hit = 1'b0;
      sb  = 0;
      if (up && db >= boff && db < blen) begin
        hit = 1'b1;
        sb  = db - boff;
      end else if (!up && db < blen) begin
        hit = 1'b1;
        sb  = db + boff;
      end
      if (hit) begin
        w.wdata[b / sldu_pkg::ElenBytes][8 * (b % sldu_pkg::ElenBytes) +: 8] = src[sb];
        w.be[b / sldu_pkg::ElenBytes][b % sldu_pkg::ElenBytes] = 1'b1;
      end
    end
    exp_words.push_back(w);
  end
endfunction

`endif

//--- testbench/tb_sldu.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the vector slide unit
// Random slides with lane gaps, checked word by word against a model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_sldu;

  localparam int unsigned NrRandInsn = 40;
  localparam int unsigned WaitLimit  = 4000;

  logic                 clk_i;
  logic                 rst_ni;
  sldu_pkg::slide_req_t req_i;
  logic                 req_valid_i;
  logic                 req_ready_o;
  sldu_pkg::lane_data_t operand_i;
  sldu_pkg::lane_bits_t operand_valid_i;
  sldu_pkg::lane_bits_t operand_ready_o;
  sldu_pkg::lane_bits_t result_req_o;
  sldu_pkg::vaddr_t     result_addr_o;
  sldu_pkg::vid_t       result_id_o;
  sldu_pkg::lane_data_t result_wdata_o;
  sldu_pkg::lane_strb_t result_be_o;
  sldu_pkg::lane_bits_t result_gnt_i;
  sldu_pkg::done_vec_t  done_o;

  logic [31:0] stim_lfsr;
  logic [31:0] lane_lfsr;

  // Expected traffic, oldest first
  sldu_pkg::lane_data_t   op_words[$];
  sldu_pkg::result_word_t exp_words[$];
  sldu_pkg::vid_t         done_q[$];

  // Accepted slides whose last word has not left yet
  int             inflight;
  logic           op_taken;
  logic           hold_gnt;
  sldu_pkg::vid_t next_id;
  // Lanes that already granted the head word
  sldu_pkg::lane_bits_t gnt_seen;

  int word_errs;
  int done_errs;
  int hs_errs;
  int timeouts;

  `include "tb_sldu_model.svh"

  sldu_top dut0 (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .result_req_o    (result_req_o),
    .result_addr_o   (result_addr_o),
    .result_id_o     (result_id_o),
    .result_wdata_o  (result_wdata_o),
    .result_be_o     (result_be_o),
    .result_gnt_i    (result_gnt_i),
    .done_o          (done_o)
  );

  always #4 clk_i = ~clk_i;

  task automatic compare_word(input sldu_pkg::result_word_t got,
                              input sldu_pkg::result_word_t exp);
    if (got.id !== exp.id || got.addr !== exp.addr) begin
      $display("Error at %0t: word id %0d addr %0d, expected id %0d addr %0d",
               $time, got.id, got.addr, exp.id, exp.addr);
      word_errs++;
    end
    for (int l = 0; l < sldu_pkg::NrLanes; l++) begin
      if (got.wdata[l] !== exp.wdata[l] || got.be[l] !== exp.be[l]) begin
        $display("Error at %0t: addr %0d lane %0d data %h be %b, expected %h be %b",
                 $time, exp.addr, l, got.wdata[l], got.be[l], exp.wdata[l], exp.be[l]);
        word_errs++;
      end
    end
  endtask

  task automatic compare_done(input sldu_pkg::done_vec_t got, input sldu_pkg::done_vec_t exp);
    if (got !== exp) begin
      $display("Error at %0t: done_o %b, expected %b", $time, got, exp);
      done_errs++;
    end
  endtask

  task automatic compare_lanes(input sldu_pkg::lane_bits_t got, input sldu_pkg::lane_bits_t exp,
                               input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s %b, expected %b", $time, what, got, exp);
      hs_errs++;
    end
  endtask

  task automatic compare_ready(input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t: req_ready_o %b, expected %b", $time, got, exp);
      hs_errs++;
    end
  endtask

  // Legal random slide within one register
  function automatic sldu_pkg::slide_req_t make_req();
    sldu_pkg::slide_req_t r;
    logic [1:0]           ew;
    int unsigned          max_el;
    r        = '0;
    r.id     = next_id;
    ew       = 2'(stim_bits(2));
    r.vsew   = sldu_pkg::vew_e'(ew);
    r.op     = stim_bits(1) ? sldu_pkg::SLIDE_DOWN : sldu_pkg::SLIDE_UP;
    max_el   = sldu_pkg::VlenBytes >> ew;
    r.vl     = sldu_pkg::blen_t'(1 + stim_bits(9) % max_el);
    if (r.op == sldu_pkg::SLIDE_UP) begin
      r.offset = sldu_pkg::blen_t'(stim_bits(9) % r.vl);
    end else begin
      r.offset = sldu_pkg::blen_t'(stim_bits(9) % (max_el - r.vl + 1));
    end
    r.vd     = sldu_pkg::vreg_t'(stim_bits(5));
    next_id  = next_id + 1'b1;
    return r;
  endfunction

  // Entered and left just after a rising edge
  task automatic send_req(input sldu_pkg::slide_req_t req);
    int   cycles;
    logic taken;
    cycles = 0;
    taken  = 1'b0;
    @(posedge clk_i);
    build_expect(req);
    #1;
    req_i       = req;
    req_valid_i = 1'b1;
    while (!taken && cycles < WaitLimit) begin
      @(negedge clk_i);
      taken = req_ready_o;
      cycles++;
    end
    if (!taken) begin
      $display("Timeout waiting for the request with id %0d to be accepted", req.id);
      timeouts++;
    end
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    int   cycles;
    logic idle;
    cycles = 0;
    idle   = 1'b0;
    while (!idle && cycles < WaitLimit) begin
      @(posedge clk_i);
      idle = (exp_words.size() == 0 && done_q.size() == 0 && inflight == 0);
      cycles++;
    end
    if (!idle) begin
      $display("Timeout waiting for all slides to finish, %0d words missing", exp_words.size());
      timeouts++;
    end
    if (op_words.size() != 0) begin
      $display("The unit left %0d operand words unread", op_words.size());
      hs_errs++;
    end
    #1;
  endtask

  // Outputs are settled mid-cycle and hold until the next edge
  always @(negedge clk_i) begin : check_outputs
    sldu_pkg::done_vec_t    exp_done;
    sldu_pkg::result_word_t got;
    sldu_pkg::result_word_t exp;
    if (rst_ni) begin
      compare_ready(req_ready_o, inflight < sldu_pkg::InsnQueueDepth);
      // Done follows the last word by exactly one cycle
      exp_done = '0;
      if (done_q.size() != 0) begin
        exp_done[done_q.pop_front()] = 1'b1;
      end
      compare_done(done_o, exp_done);
      if (operand_ready_o != '0) begin
        if (operand_ready_o != '1 || operand_valid_i != '1 || op_words.size() == 0) begin
          $display("Operand ready was raised without a full word from every lane");
          hs_errs++;
        end
        op_taken = 1'b1;
      end
      // A lane requests the head word until it has granted it
      if (result_req_o != '0) begin
        compare_lanes(result_req_o, ~gnt_seen, "result_req_o");
        gnt_seen = gnt_seen | (result_req_o & result_gnt_i);
      end
      // Head word leaves when its last lanes are granted
      if (result_req_o != '0 && (result_req_o & ~result_gnt_i) == '0) begin
        gnt_seen = '0;
        if (exp_words.size() == 0) begin
          $display("The unit wrote a result word that no slide should produce");
          word_errs++;
        end else begin
          exp       = exp_words.pop_front();
          got.id    = result_id_o;
          got.addr  = result_addr_o;
          got.wdata = result_wdata_o;
          got.be    = result_be_o;
          got.last  = exp.last;
          compare_word(got, exp);
          if (exp.last) begin
            done_q.push_back(exp.id);
            inflight--;
          end
        end
      end
      if (req_valid_i && req_ready_o) begin
        inflight++;
      end
    end
  end

  // Lanes with random valid and grant gaps
  always @(posedge clk_i) begin
    #1;
    if (op_taken) begin
      if (op_words.size() != 0) begin
        void'(op_words.pop_front());
      end
      operand_valid_i = '0;
      op_taken        = 1'b0;
    end
    for (int l = 0; l < sldu_pkg::NrLanes; l++) begin
      if (!operand_valid_i[l] && op_words.size() != 0 && lane_bits(2) != 0) begin
        operand_valid_i[l] = 1'b1;
      end
      result_gnt_i[l] = !hold_gnt && (lane_bits(2) != 0);
    end
    operand_i = (op_words.size() != 0) ? op_words[0] : '0;
  end

  initial begin
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    req_i           = '0;
    req_valid_i     = 1'b0;
    operand_i       = '0;
    operand_valid_i = '0;
    result_gnt_i    = '0;
    stim_lfsr       = 32'h2a93_8c49;
    lane_lfsr       = 32'h2a93_8c49;
    inflight        = 0;
    op_taken        = 1'b0;
    hold_gnt        = 1'b0;
    next_id         = '0;
    gnt_seen        = '0;
    word_errs       = 0;
    done_errs       = 0;
    hs_errs         = 0;
    timeouts        = 0;

    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Quiet unit after reset
    @(negedge clk_i);
    compare_ready(req_ready_o, 1'b1);
    compare_lanes(result_req_o, '0, "result_req_o");
    compare_lanes(operand_ready_o, '0, "operand_ready_o");
    compare_done(done_o, '0);
    @(posedge clk_i);
    #1;

    for (int n = 0; n < NrRandInsn; n++) begin
      send_req(make_req());
    end
    wait_idle();

    // Fill the queue with grants held, third request must wait
    @(negedge clk_i);
    hold_gnt = 1'b1;
    @(posedge clk_i);
    #1;
    send_req(make_req());
    send_req(make_req());
    fork
      send_req(make_req());
      begin
        repeat (20) @(posedge clk_i);
        @(negedge clk_i);
        compare_ready(req_ready_o, 1'b0);
        hold_gnt = 1'b0;
      end
    join
    wait_idle();

    $display("Summary: %0d word errors, %0d done errors, %0d handshake errors, %0d timeouts",
             word_errs, done_errs, hs_errs, timeouts);
    if (word_errs + done_errs + hs_errs + timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+testbench
src/sldu_pkg.sv
src/sldu_insn_queue.sv
src/sldu_slide_engine.sv
src/sldu_result_queue.sv
src/sldu_top.sv
testbench/tb_sldu.sv

//--- Bender.yml
package:
  name: sldu

sources:
  - files:
      - src/sldu_pkg.sv
      - src/sldu_insn_queue.sv
      - src/sldu_slide_engine.sv
      - src/sldu_result_queue.sv
      - src/sldu_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_sldu.sv
